/* files.f */
+incdir+.
stcModPkg.sv
stcModRegs.sv
stcSymbolClock.sv
stcDeviationGen.sv
stcInterpolator.sv
stcFreqScaler.sv
stcMod.sv
stcMod_tb.sv

/* stcDeviationGen.sv */
`timescale 1ns/10ps
`include "stcMod_consts.svh"

module stcDeviationGen (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sampleEn,
    input  logic                    bitEdge,
    input  logic                    modData0,
    input  logic                    modData1,
    input  logic                    modDataValid,
    output logic                    bitRequest,
    output logic                    devValid,
    output stcModPkg::devSample_t   deviation0,
    output stcModPkg::devSample_t   deviation1
);
    import stcModPkg::*;

    logic       reqDly;
    logic       oddBit;
    logic [1:0] dataIn;
    // per channel {b[k-2], b[k-1]}.
    logic [1:0] history [2];
    devSample_t pendDev [2];

    // SOQPSK precoder, alpha = (-1)^(k+1) * a[k-1] * (a[k] - a[k-2]) / 2.
    function automatic devSample_t ternary(input logic cur, input logic [1:0] hist,
                                           input logic odd);
        logic neg;
        if (cur == hist[1]) begin
            return '0;
        end
        neg = ~(cur ^ hist[0] ^ odd);
        return neg ? -devSample_t'(`STC_DEV_LEVEL) : devSample_t'(`STC_DEV_LEVEL);
    endfunction

    assign bitRequest = bitEdge;
    assign dataIn = {modData1, modData0};

    always_ff @(posedge clk) begin
        if (reset) begin
            reqDly     <= 1'b0;
            oddBit     <= 1'b0;
            history    <= '{default: '0};
            pendDev    <= '{default: '0};
            devValid   <= 1'b0;
            deviation0 <= '0;
            deviation1 <= '0;
        end
        else begin
            reqDly   <= bitEdge;
            devValid <= sampleEn;
            // the source answers the cycle after the request.
            if (reqDly && modDataValid) begin
                for (int ch = 0; ch < 2; ch++) begin
                    pendDev[ch] <= ternary(dataIn[ch], history[ch], oddBit);
                    history[ch] <= {history[ch][0], dataIn[ch]};
                end
                oddBit <= ~oddBit;
            end
            // symbol holds for both samples of the bit.
            if (!modDataValid) begin
                deviation0 <= '0;
                deviation1 <= '0;
            end
            else if (sampleEn && bitEdge) begin
                deviation0 <= pendDev[0];
                deviation1 <= pendDev[1];
            end
        end
    end

endmodule

/* stcFreqScaler.sv */
`timescale 1ns/10ps

module stcFreqScaler (
    input  logic                    clk,
    input  logic                    reset,
    input  stcModPkg::devSample_t   waveform,
    input  stcModPkg::mantissa_t    devMantissa,
    input  stcModPkg::exponent_t    devExponent,
    input  stcModPkg::freqWord_t    carrierFreq,
    output stcModPkg::freqWord_t    fmFreq
);
    import stcModPkg::*;

    // 18 bit sample times unsigned 18 bit mantissa.
    logic signed [36:0] product;
    freqWord_t          scaled;

    always_ff @(posedge clk) begin
        if (reset) begin
            product <= '0;
            scaled  <= '0;
            fmFreq  <= '0;
        end
        else begin
            product <= waveform * $signed({1'b0, devMantissa});
            scaled  <= freqWord_t'(product[34:3]) <<< devExponent;
            // positive deviation lowers the output word.
            fmFreq  <= carrierFreq - scaled;
        end
    end

endmodule

/* stcInterpolator.sv */
`timescale 1ns/10ps
`include "stcMod_consts.svh"

module stcInterpolator (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    input  logic                    devValid,
    input  stcModPkg::devSample_t   deviation,
    input  stcModPkg::cicShift_t    cicShift,
    output stcModPkg::devSample_t   waveform
);
    import stcModPkg::*;

    localparam int stages = `STC_CIC_STAGES;
    localparam cicWord_t satHigh = (cicWord_t'(1) <<< (`STC_DEV_WIDTH - 1)) - 1;
    localparam cicWord_t satLow = -(cicWord_t'(1) <<< (`STC_DEV_WIDTH - 1));

    cicWord_t combStage [stages+1];
    cicWord_t combDly [stages];
    cicWord_t combReg;
    cicWord_t integ [stages];
    cicWord_t integNext [stages];
    cicWord_t shifted;
    devSample_t satOut;

    ////////////////////////////////
    // comb section at sample rate, integrators at clock rate.
    always_comb begin
        combStage[0] = cicWord_t'(deviation);
        for (int i = 0; i < stages; i++) begin
            combStage[i+1] = combStage[i] - combDly[i];
        end
        integNext[0] = integ[0] + combReg;
        for (int i = 1; i < stages; i++) begin
            integNext[i] = integ[i] + integNext[i-1];
        end
    end

    ////////////////////////////////
    // gain adjust with saturation to the sample width.
    always_comb begin
        shifted = integ[stages-1] >>> cicShift;
        if (shifted > satHigh) begin
            satOut = devSample_t'(satHigh);
        end
        else if (shifted < satLow) begin
            satOut = devSample_t'(satLow);
        end
        else begin
            satOut = devSample_t'(shifted);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            combDly  <= '{default: '0};
            combReg  <= '0;
            integ    <= '{default: '0};
            waveform <= '0;
        end
        else begin
            if (devValid) begin
                for (int i = 0; i < stages; i++) begin
                    combDly[i] <= combStage[i];
                end
            end
            // zero stuffing between input samples.
            combReg  <= devValid ? combStage[stages] : '0;
            integ    <= integNext;
            waveform <= satOut;
        end
    end

endmodule

/* stcMod.sv */
`timescale 1ns/10ps
`include "stcMod_consts.svh"

module stcMod (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        txEnable,
    input  logic [`STC_ADDR_WIDTH-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`STC_ADDR_WIDTH-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic                        modData0,
    input  logic                        modData1,
    input  logic                        modDataValid,
    output logic                        bitRequest,
    output stcModPkg::devSample_t       modWaveform0,
    output stcModPkg::devSample_t       modWaveform1,
    output stcModPkg::freqWord_t        fmModFreq0,
    output stcModPkg::freqWord_t        fmModFreq1
);
    import stcModPkg::*;

    freqWord_t  carrierFreq;
    mantissa_t  devMantissa;
    exponent_t  devExponent;
    sampleDiv_t sampleDiv;
    cicShift_t  cicShift;
    logic       sampleEn;
    logic       bitEdge;
    logic       devValid;
    devSample_t deviation0;
    devSample_t deviation1;

    stcModRegs regs_i (
        .clk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .carrierFreq, .devMantissa, .devExponent, .sampleDiv, .cicShift
    );

    stcSymbolClock symClk_i (
        .clk, .reset, .txEnable, .sampleDiv, .sampleEn, .bitEdge
    );

    stcDeviationGen devGen_i (
        .clk, .reset, .sampleEn, .bitEdge, .modData0, .modData1, .modDataValid,
        .bitRequest, .devValid, .deviation0, .deviation1
    );

    ////////////////////////////////
    // channel 0.
    stcInterpolator interp0_i (
        .clk, .reset, .enable(modDataValid), .devValid,
        .deviation(deviation0), .cicShift, .waveform(modWaveform0)
    );

    stcFreqScaler scaler0_i (
        .clk, .reset, .waveform(modWaveform0), .devMantissa, .devExponent,
        .carrierFreq, .fmFreq(fmModFreq0)
    );

    ////////////////////////////////
    // channel 1.
    stcInterpolator interp1_i (
        .clk, .reset, .enable(modDataValid), .devValid,
        .deviation(deviation1), .cicShift, .waveform(modWaveform1)
    );

    stcFreqScaler scaler1_i (
        .clk, .reset, .waveform(modWaveform1), .devMantissa, .devExponent,
        .carrierFreq, .fmFreq(fmModFreq1)
    );

endmodule

/* stcModPkg.sv */
`include "stcMod_consts.svh"

package stcModPkg;

    // sample and word types.
    typedef logic signed [`STC_DEV_WIDTH-1:0]  devSample_t;
    typedef logic signed [`STC_FREQ_WIDTH-1:0] freqWord_t;
    typedef logic signed [`STC_CIC_WIDTH-1:0]  cicWord_t;

    // control register fields.
    typedef logic [`STC_MANT_WIDTH-1:0]  mantissa_t;
    typedef logic [`STC_EXP_WIDTH-1:0]   exponent_t;
    typedef logic [`STC_DIV_WIDTH-1:0]   sampleDiv_t;
    typedef logic [`STC_SHIFT_WIDTH-1:0] cicShift_t;

    // one machine serves both the write and the read channel.
    typedef enum logic [1:0] {
        axiIdle,
        axiWrResp,
        axiRdData
    } axiState_t;

endpackage

/* stcModRegs.sv */
`timescale 1ns/10ps
`include "stcMod_consts.svh"

module stcModRegs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`STC_ADDR_WIDTH-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`STC_ADDR_WIDTH-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output stcModPkg::freqWord_t        carrierFreq,
    output stcModPkg::mantissa_t        devMantissa,
    output stcModPkg::exponent_t        devExponent,
    output stcModPkg::sampleDiv_t       sampleDiv,
    output stcModPkg::cicShift_t        cicShift
);
    import stcModPkg::*;

    axiState_t  state;
    logic [7:0] wrOffset;
    logic [7:0] rdOffset;
    logic [31:0] wrMerged;
    logic [31:0] rdValue;

    function automatic logic isMapped(input logic [7:0] offset);
        return offset inside {`STC_REG_CARRIER, `STC_REG_DEV, `STC_REG_DEVEXP,
                              `STC_REG_SAMPLEDIV, `STC_REG_CICSHIFT};
    endfunction

    // stored fields as they appear on the bus, unmapped reads give zero.
    function automatic logic [31:0] regValue(input logic [7:0] offset);
        case (offset)
            `STC_REG_CARRIER:   return carrierFreq;
            `STC_REG_DEV:       return {14'b0, devMantissa};
            `STC_REG_DEVEXP:    return {12'b0, devExponent, 16'b0};
            `STC_REG_SAMPLEDIV: return {16'b0, sampleDiv};
            `STC_REG_CICSHIFT:  return {27'b0, cicShift};
            default:            return '0;
        endcase
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old,
                                               input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] result;
        result = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = data[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign wrOffset = {awaddr[`STC_ADDR_WIDTH-1:2], 2'b00};
    assign rdOffset = {araddr[`STC_ADDR_WIDTH-1:2], 2'b00};
    assign wrMerged = mergeBytes(regValue(wrOffset), wdata, wstrb);
    assign rdValue  = regValue(rdOffset);

    // writes win when both channels ask in the same cycle.
    assign awready = (state == axiIdle) && awvalid && wvalid;
    assign wready  = awready;
    assign arready = (state == axiIdle) && arvalid && !(awvalid && wvalid);
    assign bvalid  = (state == axiWrResp);
    assign rvalid  = (state == axiRdData);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= axiIdle;
            carrierFreq <= '0;
            devMantissa <= '0;
            devExponent <= '0;
            sampleDiv   <= '0;
            cicShift    <= '0;
            bresp       <= `STC_RESP_OKAY;
            rresp       <= `STC_RESP_OKAY;
            rdata       <= '0;
        end
        else begin
            case (state)
                axiIdle: begin
                    if (awready) begin
                        bresp <= isMapped(wrOffset) ? `STC_RESP_OKAY : `STC_RESP_SLVERR;
                        state <= axiWrResp;
                        case (wrOffset)
                            `STC_REG_CARRIER:   carrierFreq <= wrMerged;
                            `STC_REG_DEV:       devMantissa <= wrMerged[17:0];
                            `STC_REG_DEVEXP:    devExponent <= wrMerged[19:16];
                            `STC_REG_SAMPLEDIV: sampleDiv <= wrMerged[15:0];
                            `STC_REG_CICSHIFT:  cicShift <= wrMerged[4:0];
                            default: ;
                        endcase
                    end
                    else if (arready) begin
                        rdata <= rdValue;
                        rresp <= isMapped(rdOffset) ? `STC_RESP_OKAY : `STC_RESP_SLVERR;
                        state <= axiRdData;
                    end
                end
                axiWrResp: if (bready) state <= axiIdle;
                axiRdData: if (rready) state <= axiIdle;
                default:   state <= axiIdle;
            endcase
        end
    end

    // the response stays up until the master takes it.
    assert property (@(posedge clk) disable iff (reset) bvalid && !bready |=> bvalid);

endmodule

/* stcMod_consts.svh */
`ifndef STC_MOD_CONSTS_SVH
`define STC_MOD_CONSTS_SVH

// datapath widths.
`define STC_DEV_WIDTH       18
`define STC_FREQ_WIDTH      32
`define STC_CIC_WIDTH       34
`define STC_MANT_WIDTH      18
`define STC_EXP_WIDTH       4
`define STC_DIV_WIDTH       16
`define STC_SHIFT_WIDTH     5
`define STC_ADDR_WIDTH      8

// ternary deviation magnitude, half of full scale.
`define STC_DEV_LEVEL       65536
`define STC_CIC_STAGES      3

// register byte offsets, the exponent sits in bits 19:16 of its own word.
`define STC_REG_CARRIER     8'h00
`define STC_REG_DEV         8'h04
`define STC_REG_DEVEXP      8'h08
`define STC_REG_SAMPLEDIV   8'h0c
`define STC_REG_CICSHIFT    8'h10

`define STC_RESP_OKAY       2'b00
`define STC_RESP_SLVERR     2'b10

`endif

/* stcMod_tb.sv */
`timescale 1ns/10ps
`include "stcMod_consts.svh"

module stcMod_tb;
    import stcModPkg::*;

    localparam int clkPeriod = 8;
    // rough length of each test in clock cycles.
    localparam int regCycles = 150;
    localparam int pacingCycles = 250;
    localparam int idleCycles = 300;
    localparam int zeroDevCycles = 250;
    localparam int symCycles = 300;
    localparam int constCycles = 300;
    localparam int watchdogCycles = 2 * (regCycles + pacingCycles + idleCycles
                                         + zeroDevCycles + symCycles + constCycles);
    localparam int randomBits = 0;
    localparam int sameBits = 1;
    localparam int onesBits = 2;

    logic clk = 1'b0;
    logic reset, txEnable;
    logic [`STC_ADDR_WIDTH-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata;
    logic [3:0] wstrb;
    logic [1:0] bresp, rresp;
    logic modData0, modData1, modDataValid, bitRequest;
    devSample_t modWaveform0, modWaveform1;
    freqWord_t fmModFreq0, fmModFreq1;

    // expected values and check enables.
    logic [1:0] expBresp, expRresp;
    logic [31:0] expRdata;
    freqWord_t expCarrier;
    logic checkCarrier, checkSym;
    int curDiv, expGap, sinceReq, dataMode, seed;
    logic seenReq = 1'b0;
    int errorCount, errorsAtStart, testsPassed, testsFailed;

    stcMod dut_i (.*);

    always #(clkPeriod / 2) clk = ~clk;

    assign expGap = 2 * (curDiv + 1);

    // cycles since the last bit request.
    always @(posedge clk) begin
        if (!txEnable) begin
            seenReq <= 1'b0;
        end
        else if (bitRequest) begin
            seenReq <= 1'b1;
        end
        sinceReq <= bitRequest ? 1 : sinceReq + 1;
    end

    //////////////////////////////
    // data source answering each bit request.
    always begin
        int rnd;
        @(negedge clk);
        if (bitRequest) begin
            @(posedge clk);
            #1;
            rnd = $random(seed);
            modData0 = (dataMode == onesBits) ? 1'b1 : rnd[0];
            modData1 = (dataMode == onesBits) ? 1'b1 : (dataMode == sameBits) ? rnd[0] : rnd[1];
        end
    end

    task automatic logMismatch(input string name, input logic [31:0] expVal,
                               input logic [31:0] actVal);
        $display("ERROR at %0t ns: %s expected 0x%h, actual 0x%h", $time, name, expVal, actVal);
        errorCount++;
    endtask

    //////////////////////////////
    // checks.
    assert property (@(posedge clk) disable iff (reset)
                     (awvalid && awready) == (wvalid && wready))
        else logMismatch("wready", $sampled(awvalid && awready), $sampled(wvalid && wready));
    assert property (@(posedge clk) disable iff (reset) bvalid && bready |-> bresp == expBresp)
        else logMismatch("bresp", expBresp, $sampled(bresp));
    assert property (@(posedge clk) disable iff (reset) rvalid && rready |-> rresp == expRresp)
        else logMismatch("rresp", expRresp, $sampled(rresp));
    assert property (@(posedge clk) disable iff (reset) rvalid && rready |-> rdata == expRdata)
        else logMismatch("rdata", expRdata, $sampled(rdata));
    assert property (@(posedge clk) disable iff (reset)
                     bitRequest && seenReq |-> sinceReq == expGap)
        else logMismatch("bitRequest interval", expGap, $sampled(sinceReq));
    assert property (@(posedge clk) disable iff (reset) !txEnable |=> !bitRequest)
        else logMismatch("bitRequest", 32'd0, 32'd1);
    assert property (@(posedge clk) disable iff (reset) checkCarrier |-> fmModFreq0 == expCarrier)
        else logMismatch("fmModFreq0", expCarrier, $sampled(fmModFreq0));
    assert property (@(posedge clk) disable iff (reset) checkCarrier |-> fmModFreq1 == expCarrier)
        else logMismatch("fmModFreq1", expCarrier, $sampled(fmModFreq1));
    assert property (@(posedge clk) disable iff (reset) checkSym |-> modWaveform0 == modWaveform1)
        else logMismatch("modWaveform1", $sampled(modWaveform0), $sampled(modWaveform1));
    assert property (@(posedge clk) disable iff (reset) checkSym |-> fmModFreq0 == fmModFreq1)
        else logMismatch("fmModFreq1", $sampled(fmModFreq0), $sampled(fmModFreq1));

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic waitBitRequests(input int n);
        repeat (n) begin
            @(negedge clk);
            while (!bitRequest) @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] resp);
        expBresp = resp;
        awaddr = addr;
        wdata = data;
        wstrb = strb;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b0;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // response is held back for two cycles.
        repeat (2) @(posedge clk);
        #1;
        bready = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic readReg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] resp);
        expRdata = data;
        expRresp = resp;
        araddr = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("test %s: passed", name);
        end
        else begin
            testsFailed++;
            $display("test %s: failed with %0d errors", name, errorCount - errorsAtStart);
        end
        errorsAtStart = errorCount;
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired, the tests did not complete in time");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        seed = 47;
        reset = 1'b1;
        txEnable = 1'b0;
        {awaddr, awvalid, wdata, wstrb, wvalid, araddr, arvalid} = '0;
        bready = 1'b1;
        rready = 1'b1;
        {modData0, modData1, modDataValid} = '0;
        {checkCarrier, checkSym} = '0;
        expCarrier = '0;
        {expBresp, expRresp, expRdata} = '0;
        dataMode = randomBits;
        curDiv = 0;
        {errorCount, errorsAtStart, testsPassed, testsFailed} = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        waitCycles(2);

        // register access with byte lanes and unmapped offsets.
        writeReg(`STC_REG_CARRIER, 32'ha5c3_0f96, 4'hf, `STC_RESP_OKAY);
        readReg(`STC_REG_CARRIER, 32'ha5c3_0f96, `STC_RESP_OKAY);
        writeReg(`STC_REG_CARRIER, 32'h1122_3344, 4'b0101, `STC_RESP_OKAY);
        readReg(`STC_REG_CARRIER, 32'ha522_0f44, `STC_RESP_OKAY);
        writeReg(`STC_REG_DEV, 32'hffff_ffff, 4'hf, `STC_RESP_OKAY);
        readReg(`STC_REG_DEV, 32'h0003_ffff, `STC_RESP_OKAY);
        writeReg(`STC_REG_DEV, 32'h0000_0000, 4'b0010, `STC_RESP_OKAY);
        readReg(`STC_REG_DEV, 32'h0003_00ff, `STC_RESP_OKAY);
        writeReg(`STC_REG_DEVEXP, 32'h000a_0000, 4'hf, `STC_RESP_OKAY);
        readReg(`STC_REG_DEVEXP, 32'h000a_0000, `STC_RESP_OKAY);
        writeReg(`STC_REG_DEVEXP, 32'h00f5_0000, 4'b0100, `STC_RESP_OKAY);
        readReg(`STC_REG_DEVEXP, 32'h0005_0000, `STC_RESP_OKAY);
        writeReg(`STC_REG_SAMPLEDIV, 32'h1234_abcd, 4'hf, `STC_RESP_OKAY);
        readReg(`STC_REG_SAMPLEDIV, 32'h0000_abcd, `STC_RESP_OKAY);
        writeReg(`STC_REG_CICSHIFT, 32'hffff_ffff, 4'hf, `STC_RESP_OKAY);
        readReg(`STC_REG_CICSHIFT, 32'h0000_001f, `STC_RESP_OKAY);
        writeReg(8'h20, 32'hdead_beef, 4'hf, `STC_RESP_SLVERR);
        readReg(8'h20, 32'h0000_0000, `STC_RESP_SLVERR);
        finishTest("register access");

        // bit pacing for two dividers.
        writeReg(`STC_REG_SAMPLEDIV, 32'd3, 4'hf, `STC_RESP_OKAY);
        curDiv = 3;
        txEnable = 1'b1;
        waitBitRequests(6);
        txEnable = 1'b0;
        waitCycles(30);
        writeReg(`STC_REG_SAMPLEDIV, 32'd6, 4'hf, `STC_RESP_OKAY);
        curDiv = 6;
        txEnable = 1'b1;
        waitBitRequests(6);
        txEnable = 1'b0;
        waitCycles(10);
        finishTest("bit pacing");

        // idle carrier before and after valid data.
        writeReg(`STC_REG_CARRIER, 32'h2000_0000, 4'hf, `STC_RESP_OKAY);
        expCarrier = 32'h2000_0000;
        writeReg(`STC_REG_DEV, 32'd4096, 4'hf, `STC_RESP_OKAY);
        writeReg(`STC_REG_DEVEXP, 32'h0002_0000, 4'hf, `STC_RESP_OKAY);
        writeReg(`STC_REG_SAMPLEDIV, 32'd3, 4'hf, `STC_RESP_OKAY);
        curDiv = 3;
        writeReg(`STC_REG_CICSHIFT, 32'd4, 4'hf, `STC_RESP_OKAY);
        waitCycles(4);
        checkCarrier = 1'b1;
        txEnable = 1'b1;
        waitBitRequests(4);
        checkCarrier = 1'b0;
        modDataValid = 1'b1;
        waitBitRequests(10);
        modDataValid = 1'b0;
        waitCycles(7);
        checkCarrier = 1'b1;
        waitBitRequests(10);
        checkCarrier = 1'b0;
        finishTest("idle carrier");

        // zero mantissa under random data.
        writeReg(`STC_REG_DEV, 32'd0, 4'hf, `STC_RESP_OKAY);
        waitCycles(4);
        checkCarrier = 1'b1;
        modDataValid = 1'b1;
        waitBitRequests(20);
        checkCarrier = 1'b0;
        writeReg(`STC_REG_DEV, 32'd4096, 4'hf, `STC_RESP_OKAY);
        finishTest("zero deviation");

        // same bits on both channels once the histories and CIC have lined up.
        dataMode = sameBits;
        waitBitRequests(6);
        waitCycles(7 + 6 * (curDiv + 1));
        checkSym = 1'b1;
        waitBitRequests(20);
        checkSym = 1'b0;
        finishTest("channel symmetry");

        // all ones gives zero symbols after two bits.
        dataMode = onesBits;
        waitBitRequests(6);
        waitCycles(7 + 6 * (curDiv + 1));
        checkCarrier = 1'b1;
        waitBitRequests(20);
        checkCarrier = 1'b0;
        finishTest("constant data");

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end
        else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* stcSymbolClock.sv */
`timescale 1ns/10ps

module stcSymbolClock (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    txEnable,
    input  stcModPkg::sampleDiv_t   sampleDiv,
    output logic                    sampleEn,
    output logic                    bitEdge
);
    import stcModPkg::*;

    sampleDiv_t count;
    // low on the first sample of a bit.
    logic       phase;

    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            phase    <= 1'b0;
            sampleEn <= 1'b0;
            bitEdge  <= 1'b0;
        end
        else if (!txEnable) begin
            count    <= sampleDiv;
            phase    <= 1'b0;
            sampleEn <= 1'b0;
            bitEdge  <= 1'b0;
        end
        else if (count == '0) begin
            count    <= sampleDiv;
            phase    <= ~phase;
            sampleEn <= 1'b1;
            bitEdge  <= ~phase;
        end
        else begin
            count    <= count - 1'b1;
            sampleEn <= 1'b0;
            bitEdge  <= 1'b0;
        end
    end

    // a bit boundary is always a sample boundary.
    assert property (@(posedge clk) disable iff (reset) bitEdge |-> sampleEn);

endmodule
